//--- Makefile
# Verilator build for the commit trace block

VERILATOR  ?= verilator
TOP        := tb_commit_trace
RTL_TOP    := commit_trace
FILELIST   := filelist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hw/trace_pkg.sv
hw/commit_filter.sv
hw/pc_queue.sv
hw/trace_drain.sv
hw/commit_trace.sv
sim/tb_clock.sv
sim/tb_commit_trace.sv

//--- hw/commit_filter.sv
// Commit filter: registers the commit ports, keeps clean retirements, tags mode, counts exceptions
`timescale 1ns/10ps
`default_nettype none

module commit_filter (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Commit ports
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      commit_ack_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] commit_pc_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      commit_ex_valid_i,
  // Current mode
  input  trace_pkg::priv_lvl_t                                       priv_lvl_i,
  input  logic                                                       debug_mode_i,
  // Towards the PC queues
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      push_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] push_pc_o,
  output trace_pkg::trace_mode_t [trace_pkg::NR_COMMIT_PORTS-1:0]    push_mode_o,
  output logic [trace_pkg::CNT_WIDTH-1:0]                            exc_count_o
);

  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      push_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] pc_q;
  trace_pkg::trace_mode_t                                     mode_d;
  trace_pkg::trace_mode_t                                     mode_q;
  logic [trace_pkg::CNT_WIDTH-1:0]                            exc_count_q;

  // ----------------------------------------------------------
  // Mode tag
  // ----------------------------------------------------------
  // Debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode_d = trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        trace_pkg::PRIV_LVL_U: mode_d = trace_pkg::MODE_U;
        trace_pkg::PRIV_LVL_S: mode_d = trace_pkg::MODE_S;
        // Reserved encoding reported as machine
        default:               mode_d = trace_pkg::MODE_M;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q      <= '0;
      exc_count_q <= '0;
    end else begin
      push_q      <= commit_ack_i & ~commit_ex_valid_i;
      exc_count_q <= exc_count_q + trace_pkg::count_ones(commit_ack_i & commit_ex_valid_i);
    end
  end

  // PC and mode only matter while the matching push is high
  always_ff @(posedge clk_i) begin
    pc_q   <= commit_pc_i;
    mode_q <= mode_d;
  end

  assign push_o      = push_q;
  assign push_pc_o   = pc_q;
  assign exc_count_o = exc_count_q;

  // All ports retire under the same mode
  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      push_mode_o[i] = mode_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/commit_trace.sv
// Commit trace top level: commit filter, per-port PC queues and round-robin trace drain
`timescale 1ns/10ps
`default_nettype none

module commit_trace (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Commit ports from the core
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      commit_ack_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] commit_pc_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      commit_ex_valid_i,
  input  trace_pkg::priv_lvl_t                                       priv_lvl_i,
  input  logic                                                       debug_mode_i,
  // Trace stream
  output logic                                                       trace_valid_o,
  output logic [trace_pkg::VLEN-1:0]                                 trace_pc_o,
  output trace_pkg::trace_mode_t                                     trace_mode_o,
  output logic [trace_pkg::PORT_IDX_WIDTH-1:0]                       trace_port_o,
  // Statistics
  output logic [trace_pkg::CNT_WIDTH-1:0]                            exc_count_o,
  output logic [trace_pkg::CNT_WIDTH-1:0]                            drop_count_o
);

  // Filter to queues
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      push;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] push_pc;
  trace_pkg::trace_mode_t [trace_pkg::NR_COMMIT_PORTS-1:0]    push_mode;
  // Queues to drain
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      q_empty;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] q_head_pc;
  trace_pkg::trace_mode_t [trace_pkg::NR_COMMIT_PORTS-1:0]    q_head_mode;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      q_overflow;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      q_pop;

  // ----------------------------------------------------------
  // Commit filter
  // ----------------------------------------------------------
  commit_filter i_commit_filter (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .push_o            ( push              ),
    .push_pc_o         ( push_pc           ),
    .push_mode_o       ( push_mode         ),
    .exc_count_o       ( exc_count_o       )
  );

  // ----------------------------------------------------------
  // One queue per commit port
  // ----------------------------------------------------------
  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_pc_queue
    pc_queue i_pc_queue (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .push_i      ( push[i]        ),
      .push_pc_i   ( push_pc[i]     ),
      .push_mode_i ( push_mode[i]   ),
      .pop_i       ( q_pop[i]       ),
      .empty_o     ( q_empty[i]     ),
      .head_pc_o   ( q_head_pc[i]   ),
      .head_mode_o ( q_head_mode[i] ),
      .overflow_o  ( q_overflow[i]  )
    );
  end

  // ----------------------------------------------------------
  // Drain into the trace stream
  // ----------------------------------------------------------
  trace_drain i_trace_drain (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .empty_i       ( q_empty       ),
    .head_pc_i     ( q_head_pc     ),
    .head_mode_i   ( q_head_mode   ),
    .overflow_i    ( q_overflow    ),
    .pop_o         ( q_pop         ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_mode_o  ( trace_mode_o  ),
    .trace_port_o  ( trace_port_o  ),
    .drop_count_o  ( drop_count_o  )
  );

endmodule

`default_nettype wire

//--- hw/pc_queue.sv
// PC queue: circular buffer of tagged PCs for one commit port with overflow strobe
`timescale 1ns/10ps
`default_nettype none

module pc_queue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Write side
  input  logic                       push_i,
  input  logic [trace_pkg::VLEN-1:0] push_pc_i,
  input  trace_pkg::trace_mode_t     push_mode_i,
  // Read side
  input  logic                       pop_i,
  output logic                       empty_o,
  output logic [trace_pkg::VLEN-1:0] head_pc_o,
  output trace_pkg::trace_mode_t     head_mode_o,
  // Push lost because the queue was full
  output logic                       overflow_o
);

  logic [trace_pkg::VLEN-1:0]            pc_mem [trace_pkg::PC_QUEUE_DEPTH];
  trace_pkg::trace_mode_t                mode_mem [trace_pkg::PC_QUEUE_DEPTH];
  logic [trace_pkg::QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
  logic [trace_pkg::QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
  logic [trace_pkg::QUEUE_CNT_WIDTH-1:0] count_q;
  logic                                  full;
  logic                                  empty;
  logic                                  do_push;
  logic                                  do_pop;

  assign full    = (count_q == trace_pkg::QUEUE_CNT_WIDTH'(trace_pkg::PC_QUEUE_DEPTH));
  assign empty   = (count_q == '0);
  // A pop in the same cycle does not make room for a push on a full queue
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == trace_pkg::QUEUE_PTR_WIDTH'(trace_pkg::PC_QUEUE_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == trace_pkg::QUEUE_PTR_WIDTH'(trace_pkg::PC_QUEUE_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      pc_mem[wr_ptr_q]   <= push_pc_i;
      mode_mem[wr_ptr_q] <= push_mode_i;
    end
  end

  assign empty_o     = empty;
  assign head_pc_o   = pc_mem[rd_ptr_q];
  assign head_mode_o = mode_mem[rd_ptr_q];
  assign overflow_o  = push_i & full;

endmodule

`default_nettype wire

//--- hw/trace_drain.sv
// Trace drain: round-robin pop of the PC queues into the registered trace output, drop counter
`timescale 1ns/10ps
`default_nettype none

module trace_drain (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Queue heads
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      empty_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] head_pc_i,
  input  trace_pkg::trace_mode_t [trace_pkg::NR_COMMIT_PORTS-1:0]    head_mode_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      overflow_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      pop_o,
  // Trace stream
  output logic                                                       trace_valid_o,
  output logic [trace_pkg::VLEN-1:0]                                 trace_pc_o,
  output trace_pkg::trace_mode_t                                     trace_mode_o,
  output logic [trace_pkg::PORT_IDX_WIDTH-1:0]                       trace_port_o,
  output logic [trace_pkg::CNT_WIDTH-1:0]                            drop_count_o
);

  logic [trace_pkg::PORT_IDX_WIDTH-1:0] last_gnt_q;
  logic [trace_pkg::PORT_IDX_WIDTH-1:0] gnt_idx;
  logic                                 gnt_valid;
  logic                                 valid_q;
  logic [trace_pkg::VLEN-1:0]           pc_q;
  trace_pkg::trace_mode_t               mode_q;
  logic [trace_pkg::PORT_IDX_WIDTH-1:0] port_q;
  logic [trace_pkg::CNT_WIDTH-1:0]      drop_count_q;

  // ----------------------------------------------------------
  // Round-robin arbiter
  // ----------------------------------------------------------
  // Search starts at the port after the last grant
  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 1; k <= trace_pkg::NR_COMMIT_PORTS; k++) begin
      cand = (int'(last_gnt_q) + k) % trace_pkg::NR_COMMIT_PORTS;
      if (!gnt_valid && !empty_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = trace_pkg::PORT_IDX_WIDTH'(cand);
      end
    end
  end

  // One-hot pop, never more than one queue per cycle
  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      pop_o[i] = gnt_valid && (gnt_idx == trace_pkg::PORT_IDX_WIDTH'(i));
    end
  end

  // ----------------------------------------------------------
  // Control state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Last grant on the top port so that port 0 wins first
      last_gnt_q   <= trace_pkg::PORT_IDX_WIDTH'(trace_pkg::NR_COMMIT_PORTS - 1);
      valid_q      <= 1'b0;
      drop_count_q <= '0;
    end else begin
      valid_q      <= gnt_valid;
      drop_count_q <= drop_count_q + trace_pkg::count_ones(overflow_i);
      if (gnt_valid) begin
        last_gnt_q <= gnt_idx;
      end
    end
  end

  // Trace payload, qualified by trace_valid_o
  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      pc_q   <= head_pc_i[gnt_idx];
      mode_q <= head_mode_i[gnt_idx];
      port_q <= gnt_idx;
    end
  end

  assign trace_valid_o = valid_q;
  assign trace_pc_o    = pc_q;
  assign trace_mode_o  = mode_q;
  assign trace_port_o  = port_q;
  assign drop_count_o  = drop_count_q;

endmodule

`default_nettype wire

//--- hw/trace_pkg.sv
// Commit trace package: sizes, counter width, privilege and trace mode types, bit count helper
`default_nettype none

package trace_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned VLEN            = 39;
  localparam int unsigned PORT_IDX_WIDTH  = (NR_COMMIT_PORTS > 1) ? $clog2(NR_COMMIT_PORTS) : 1;
  localparam int unsigned PC_QUEUE_DEPTH  = 16;
  localparam int unsigned QUEUE_PTR_WIDTH = $clog2(PC_QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_WIDTH = $clog2(PC_QUEUE_DEPTH + 1);
  localparam int unsigned CNT_WIDTH       = 32;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  // Privilege level as the core encodes it, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // Tag carried with every traced PC
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_M = 2'b10,
    MODE_D = 2'b11
  } trace_mode_t;

  // Number of set bits across the commit ports, sized for the counters
  function automatic logic [CNT_WIDTH-1:0] count_ones(input logic [NR_COMMIT_PORTS-1:0] vec);
    logic [CNT_WIDTH-1:0] sum;
    sum = '0;
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      sum = sum + CNT_WIDTH'(vec[i]);
    end
    return sum;
  endfunction

endpackage

`default_nettype wire

//--- sim/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset low for the first 2 cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_commit_trace.sv
// Testbench for commit_trace: random commit stimulus, per-port reference queues, assertions
`timescale 1ns/10ps
`default_nettype none

module tb_commit_trace;

  localparam int NR            = trace_pkg::NR_COMMIT_PORTS;
  localparam int LIGHT_CYCLES  = 300;
  localparam int EXC_CYCLES    = 120;
  localparam int BURST_CYCLES  = 3 * trace_pkg::PC_QUEUE_DEPTH;
  localparam int IDLE_CYCLES   = 8;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int RESET_TIMEOUT = 20;

  typedef logic [trace_pkg::VLEN-1:0] pc_t;
  typedef logic [trace_pkg::VLEN+1:0] entry_t;

  logic                                       clk;
  logic                                       rst_n;
  logic [NR-1:0]                              commit_ack;
  logic [NR-1:0][trace_pkg::VLEN-1:0]         commit_pc;
  logic [NR-1:0]                              commit_ex;
  trace_pkg::priv_lvl_t                       priv_lvl;
  logic                                       debug_mode;
  logic                                       trace_valid;
  logic [trace_pkg::VLEN-1:0]                 trace_pc;
  trace_pkg::trace_mode_t                     trace_mode;
  logic [trace_pkg::PORT_IDX_WIDTH-1:0]       trace_port;
  logic [trace_pkg::CNT_WIDTH-1:0]            exc_count;
  logic [trace_pkg::CNT_WIDTH-1:0]            drop_count;

  // Reference model state
  entry_t exp_q [NR][$];
  pc_t    next_pc [NR];
  int     seed = 42622;
  int     exp_exc;
  int     offered_total;
  int     traced_total;
  int     skipped_total;
  int     cycle_count;
  int     first_busy;
  int     last_busy;
  int     err_count;
  int     tests_failed;
  bit     skip_drops;

  tb_clock i_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_trace dut_i (
    .clk_i             ( clk         ),
    .rst_ni            ( rst_n       ),
    .commit_ack_i      ( commit_ack  ),
    .commit_pc_i       ( commit_pc   ),
    .commit_ex_valid_i ( commit_ex   ),
    .priv_lvl_i        ( priv_lvl    ),
    .debug_mode_i      ( debug_mode  ),
    .trace_valid_o     ( trace_valid ),
    .trace_pc_o        ( trace_pc    ),
    .trace_mode_o      ( trace_mode  ),
    .trace_port_o      ( trace_port  ),
    .exc_count_o       ( exc_count   ),
    .drop_count_o      ( drop_count  )
  );

  // ----------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------
  task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic require_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      err_count++;
    end
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    int n;
    n = err_count - errs_at_start;
    if (n == 0) begin
      $display("[test] %s: ok", name);
    end else begin
      $display("[test] %s: failed with %0d errors", name, n);
      tests_failed++;
    end
  endtask

  // Expected trace tag for a privilege level and debug flag
  function automatic trace_pkg::trace_mode_t mode_of(input trace_pkg::priv_lvl_t priv,
                                                     input logic dbg);
    if (dbg) begin
      return trace_pkg::MODE_D;
    end
    case (priv)
      trace_pkg::PRIV_LVL_U: return trace_pkg::MODE_U;
      trace_pkg::PRIV_LVL_S: return trace_pkg::MODE_S;
      default:               return trace_pkg::MODE_M;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Stimulus helpers, called on a falling edge
  // ----------------------------------------------------------
  task automatic pick_priv(input logic [1:0] sel);
    case (sel)
      2'd0:    priv_lvl = trace_pkg::PRIV_LVL_U;
      2'd1:    priv_lvl = trace_pkg::PRIV_LVL_S;
      default: priv_lvl = trace_pkg::PRIV_LVL_M;
    endcase
  endtask

  task automatic apply_commit(input logic [NR-1:0] ack, input logic [NR-1:0] ex);
    for (int p = 0; p < NR; p++) begin
      if (ack[p]) begin
        commit_pc[p] = next_pc[p];
        next_pc[p]   = next_pc[p] + pc_t'(4);
        if (ex[p]) begin
          exp_exc++;
        end else begin
          exp_q[p].push_back({mode_of(priv_lvl, debug_mode), commit_pc[p]});
          offered_total++;
        end
      end else begin
        // Junk PC on idle ports
        commit_pc[p] = pc_t'($random(seed));
      end
    end
    commit_ack = ack;
    commit_ex  = ex;
  endtask

  // At most one ack every other cycle with occasional mode changes
  task automatic run_light(input int cycles, input int ex_thresh);
    logic [31:0]   rnd;
    logic [NR-1:0] ack;
    logic [NR-1:0] ex;
    bit            acked_last;
    acked_last = 1'b0;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      rnd = $random(seed);
      ack = '0;
      ex  = '0;
      if (rnd[15:11] == 5'd0) begin
        pick_priv(rnd[17:16]);
      end
      if (rnd[23:19] == 5'd0) begin
        debug_mode = ~debug_mode;
      end
      if (!acked_last && rnd[2:0] < 3'd4) begin
        ack[int'(rnd[10:8]) % NR] = 1'b1;
      end
      ex[int'(rnd[26:24]) % NR] = (int'(rnd[7:4]) < ex_thresh);
      apply_commit(ack, ex);
      acked_last = (ack != '0);
    end
    @(negedge clk);
    apply_commit('0, '0);
  endtask

  // Waits until the trace has been quiet for a while
  task automatic wait_drain_idle(input string where);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < IDLE_CYCLES && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      quiet = trace_valid ? 0 : quiet + 1;
    end
    require_true(quiet >= IDLE_CYCLES, {"trace stream never went idle during ", where});
  endtask

  task automatic expect_queues_empty(input string where);
    for (int p = 0; p < NR; p++) begin
      require_true(exp_q[p].size() == 0,
                   $sformatf("port %0d still expects %0d entries after %s",
                             p, exp_q[p].size(), where));
    end
  endtask

  // ----------------------------------------------------------
  // Monitor
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
    end
  end

  always @(negedge clk) begin
    int     port;
    int     idx;
    entry_t exp;
    if (rst_n && trace_valid) begin
      traced_total++;
      port = int'(trace_port);
      // Under overload, entries lost to a full queue are skipped
      if (skip_drops) begin
        if (first_busy < 0) begin
          first_busy = cycle_count;
        end
        last_busy = cycle_count;
        idx = -1;
        for (int i = 0; i < exp_q[port].size(); i++) begin
          if (idx < 0 && exp_q[port][i][trace_pkg::VLEN-1:0] == trace_pc) begin
            idx = i;
          end
        end
        for (int i = 0; i < idx; i++) begin
          void'(exp_q[port].pop_front());
          skipped_total++;
        end
      end
      require_true(exp_q[port].size() != 0,
                   $sformatf("trace entry on port %0d with no entry expected", port));
      if (exp_q[port].size() != 0) begin
        exp = exp_q[port].pop_front();
        expect_equal("trace_pc_o", 64'(trace_pc), 64'(exp[trace_pkg::VLEN-1:0]));
        expect_equal("trace_mode_o", 64'(trace_mode),
                     64'(exp[trace_pkg::VLEN+1:trace_pkg::VLEN]));
      end
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int e0;
    int waited;
    int t0;
    commit_ack = '0;
    commit_pc  = '0;
    commit_ex  = '0;
    priv_lvl   = trace_pkg::PRIV_LVL_M;
    debug_mode = 1'b0;
    skip_drops = 1'b0;
    first_busy = -1;
    last_busy  = -1;
    for (int p = 0; p < NR; p++) begin
      next_pc[p] = (pc_t'(p) << (trace_pkg::VLEN - 2)) | (pc_t'($random(seed)) & ~pc_t'(3));
    end

    // Reset
    e0     = err_count;
    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    require_true(rst_n === 1'b1, "reset was never released");
    repeat (4) begin
      @(negedge clk);
      expect_equal("trace_valid_o", 64'(trace_valid), 64'(0));
      expect_equal("exc_count_o", 64'(exc_count), 64'(0));
      expect_equal("drop_count_o", 64'(drop_count), 64'(0));
    end
    close_test("reset", e0);

    // Light load ordering
    e0 = err_count;
    run_light(LIGHT_CYCLES, 2);
    wait_drain_idle("light load");
    expect_queues_empty("light load");
    expect_equal("drop_count_o", 64'(drop_count), 64'(0));
    close_test("light load order", e0);

    // Every privilege level with and without debug mode
    e0 = err_count;
    for (int d = 1; d >= 0; d--) begin
      for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 4; k++) begin
          @(negedge clk);
          debug_mode = logic'(d);
          pick_priv(2'(s));
          apply_commit(NR'(1) << (k % NR), '0);
          @(negedge clk);
          apply_commit('0, '0);
        end
      end
    end
    wait_drain_idle("mode tagging");
    expect_queues_empty("mode tagging");
    close_test("mode tagging", e0);

    // Exception heavy traffic
    e0 = err_count;
    run_light(EXC_CYCLES, 10);
    wait_drain_idle("exception traffic");
    expect_queues_empty("exception traffic");
    expect_equal("exc_count_o", 64'(exc_count), 64'(exp_exc));
    close_test("exception counter", e0);

    // Overload, both ports every cycle
    e0         = err_count;
    skip_drops = 1'b1;
    t0         = traced_total;
    for (int c = 0; c < BURST_CYCLES; c++) begin
      @(negedge clk);
      apply_commit('1, '0);
    end
    @(negedge clk);
    apply_commit('0, '0);
    wait_drain_idle("overload");
    // One entry per cycle, back to back, while the queues hold entries
    require_true((traced_total - t0) == (last_busy - first_busy + 1),
                 "trace stream did not deliver one entry per cycle during overload");
    expect_equal("drop_count_o", 64'(drop_count), 64'(offered_total - traced_total));
    require_true(drop_count != '0, "no entry was dropped under overload");
    // Entries dropped at the tail of a queue remain in the model
    for (int p = 0; p < NR; p++) begin
      skipped_total += exp_q[p].size();
      exp_q[p].delete();
    end
    expect_equal("drop_count_o", 64'(drop_count), 64'(skipped_total));
    close_test("overload", e0);

    $display("Summary: 5 tests, %0d failed, %0d errors, %0d traced, %0d dropped",
             tests_failed, err_count, traced_total, drop_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
